/* Makefile */
# Verilator build and run of the image core testbench
TOP := imageCore_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -Iinclude --top-module $(TOP) -f imageCore.f

# Pass only when the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* imageCore.f */
+incdir+include
src/isaPkg.sv
src/ctrlPkg.sv
src/controlUnit.sv
src/registerFile.sv
src/pixelAlu.sv
src/pixelMemory.sv
src/imageCore.sv
testbench/clockGen.sv
testbench/imageCore_tb.sv

/* include/imageCore_config.svh */
`ifndef IMAGECORE_CONFIG_SVH
`define IMAGECORE_CONFIG_SVH

// Register, operand and result width
`define DATA_WIDTH 32

// Register count, 5-bit register address
`define REG_COUNT 32

// Pixel memory size in bytes
// Byte address is the low 10 bits of the ALU result
`define MEM_BYTES 1024

`endif

/* src/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "imageCore_config.svh"

module controlUnit
(
	input  wire                             CLK,
	input  wire                             rstN,
	input  wire isaPkg::functCode           funct,
	input  wire                             opcode,
	input  wire [$clog2(`REG_COUNT)-1:0]    Rd,
	input  wire                             instrValid,
	output logic                            ALUSrcE,
	output ctrlPkg::aluOp                   ALUControlE,
	output ctrlPkg::wbSel                   MemtoRegW,
	output logic                            RegWriteD,
	output logic [$clog2(`REG_COUNT)-1:0]   RdD,
	output logic                            PlusOne,
	output logic                            InmRegSel,
	output logic                            MemSelE,
	output logic                            MemWriteE
);
	import isaPkg::*;
	import ctrlPkg::*;

	// One decoded control set per edge
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			ALUSrcE     <= 1'b0;
			ALUControlE <= aluAdd;
			MemtoRegW   <= wbAlu;
			RegWriteD   <= 1'b0;
			RdD         <= '0;
			PlusOne     <= 1'b0;
			InmRegSel   <= 1'b0;
			MemSelE     <= 1'b0;
			MemWriteE   <= 1'b0;
		end
		else
		begin
			// No-operation unless a listed funct arrives with valid
			ALUSrcE     <= 1'b0;
			ALUControlE <= aluAdd;
			MemtoRegW   <= wbAlu;
			RegWriteD   <= 1'b0;
			RdD         <= Rd;
			PlusOne     <= 1'b0;
			InmRegSel   <= 1'b0;
			MemSelE     <= 1'b0;
			MemWriteE   <= 1'b0;
			if (instrValid)
			begin
				case (funct)
					fnSum, fnSub, fnMul, fnGray:
					begin
						ALUSrcE   <= opcode;
						RegWriteD <= 1'b1;
						// Arithmetic op per funct
						case (funct)
							fnSub:   ALUControlE <= aluSub;
							fnMul:   ALUControlE <= aluMul;
							fnGray:  ALUControlE <= aluGray;
							default: ALUControlE <= aluSum;
						endcase
					end
					fnLoad, fnLoadAligned:
					begin
						// Address is Rn plus Rm or immediate
						ALUSrcE   <= opcode;
						RegWriteD <= 1'b1;
						MemSelE   <= 1'b1;
						MemtoRegW <= (funct == fnLoadAligned) ? wbMemWord : wbMemByte;
					end
					fnStore, fnStorePlusOne:
					begin
						// Address always Rn plus Rm, flag picks the data
						MemtoRegW <= wbMemByte;
						MemSelE   <= 1'b1;
						MemWriteE <= 1'b1;
						InmRegSel <= opcode;
						PlusOne   <= (funct == fnStorePlusOne);
					end
					default:
					begin
						RegWriteD <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

	// ALU operations
	// aluAdd for address calculation, aluSum for arithmetic
	typedef enum logic [3:0]
	{
		aluAdd  = 4'b0000,
		aluSum  = 4'b0001,
		aluSub  = 4'b0010,
		aluMul  = 4'b0011,
		aluGray = 4'b0111
	} aluOp;

	// Writeback source select
	typedef enum logic [1:0]
	{
		wbMemByte = 2'b00,
		wbAlu     = 2'b01,
		wbMemWord = 2'b10
	} wbSel;

endpackage

`default_nettype wire

/* src/imageCore.sv */
`timescale 1ns/1ns
`default_nettype none
`include "imageCore_config.svh"

module imageCore
(
	input  wire                            CLK,
	input  wire                            rstN,
	input  wire [31:0]                     instr,
	input  wire                            instrValid,
	output logic                           wbValid,
	output logic [$clog2(`REG_COUNT)-1:0]  wbAddr,
	output logic [`DATA_WIDTH-1:0]         wbData
);
	import isaPkg::*;
	import ctrlPkg::*;

	localparam int regAddrW = $clog2(`REG_COUNT);
	localparam int memAddrW = $clog2(`MEM_BYTES);

	// Decode-stage fields
	functCode                  fieldFunct;
	logic                      fieldImmFlag;
	logic [regAddrW-1:0]       fieldRd;
	logic [regAddrW-1:0]       fieldRn;
	logic [regAddrW-1:0]       fieldRm;
	logic [immMsb-immLsb:0]    fieldImm;
	logic [regAddrW-1:0]       portBAddr;
	logic [`DATA_WIDTH-1:0]    rfDataA;
	logic [`DATA_WIDTH-1:0]    rfDataB;
	logic [`DATA_WIDTH-1:0]    shadowDataA;

	// Execute-stage controls
	logic                      ALUSrcE;
	aluOp                      ALUControlE;
	wbSel                      MemtoRegW;
	logic                      RegWriteD;
	logic [regAddrW-1:0]       RdD;
	logic                      PlusOne;
	logic                      InmRegSel;
	logic                      MemSelE;
	logic                      MemWriteE;

	// D/E operands and execute results
	logic [`DATA_WIDTH-1:0]    opAE;
	logic [`DATA_WIDTH-1:0]    opBE;
	logic [`DATA_WIDTH-1:0]    rmE;
	logic [`DATA_WIDTH-1:0]    immE;
	logic [`DATA_WIDTH-1:0]    aluB;
	logic [`DATA_WIDTH-1:0]    aluResult;
	logic [7:0]                storeByteE;
	logic [7:0]                memReadByte;
	logic [`DATA_WIDTH-1:0]    memReadWord;

	// E/W payload
	wbSel                      wbSelW;
	logic [`DATA_WIDTH-1:0]    aluResW;

	always_comb
	begin
		fieldFunct   = functCode'(instr[functMsb:functLsb]);
		fieldImmFlag = instr[immFlagBit];
		fieldRd      = instr[rdMsb:rdLsb];
		fieldRn      = instr[rnMsb:rnLsb];
		fieldRm      = instr[rmMsb:rmLsb];
		fieldImm     = instr[immMsb:immLsb];
		// Stores read Rd on port B for the data
		if (fieldFunct == fnStore || fieldFunct == fnStorePlusOne)
			portBAddr = fieldRd;
		else
			portBAddr = fieldRm;
	end

	controlUnit i_controlUnit (
		.CLK(CLK), .rstN(rstN), .funct(fieldFunct), .opcode(fieldImmFlag),
		.Rd(fieldRd), .instrValid(instrValid), .ALUSrcE(ALUSrcE),
		.ALUControlE(ALUControlE), .MemtoRegW(MemtoRegW), .RegWriteD(RegWriteD),
		.RdD(RdD), .PlusOne(PlusOne), .InmRegSel(InmRegSel), .MemSelE(MemSelE),
		.MemWriteE(MemWriteE)
	);

	registerFile i_registerFile (
		.CLK(CLK), .rstN(rstN), .readAddrA(fieldRn), .readAddrB(portBAddr),
		.readDataA(rfDataA), .readDataB(rfDataB), .writeEn(wbValid),
		.writeAddr(wbAddr), .writeData(wbData)
	);

	// Shadow copy gives a third read, Rm for the store address
	registerFile i_regShadow (
		.CLK(CLK), .rstN(rstN), .readAddrA(fieldRm), .readAddrB(fieldRm),
		.readDataA(shadowDataA), .readDataB(), .writeEn(wbValid),
		.writeAddr(wbAddr), .writeData(wbData)
	);

	// D/E register
	always_ff @(posedge CLK)
	begin
		opAE <= rfDataA;
		opBE <= rfDataB;
		rmE  <= shadowDataA;
		immE <= `DATA_WIDTH'(fieldImm);
	end

	always_comb
	begin
		// Stores add Rm, others take immediate or port B
		if (MemWriteE)
			aluB = rmE;
		else
			aluB = ALUSrcE ? immE : opBE;
		storeByteE = (InmRegSel ? immE[7:0] : opBE[7:0]) + {7'b0, PlusOne};
	end

	pixelAlu i_pixelAlu (.op(ALUControlE), .a(opAE), .b(aluB), .result(aluResult));

	pixelMemory i_pixelMemory (
		.CLK(CLK), .addr(aluResult[memAddrW-1:0]), .writeEn(MemSelE & MemWriteE),
		.writeByte(storeByteE), .readByte(memReadByte), .readWord(memReadWord)
	);

	// E/W register
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
			wbValid <= 1'b0;
		else
			wbValid <= RegWriteD;
	end

	always_ff @(posedge CLK)
	begin
		wbAddr  <= RdD;
		wbSelW  <= MemtoRegW;
		aluResW <= aluResult;
	end

	// Writeback source
	always_comb
	begin
		case (wbSelW)
			wbMemByte: wbData = `DATA_WIDTH'(memReadByte);
			wbMemWord: wbData = memReadWord;
			default:   wbData = aluResW;
		endcase
	end

endmodule

`default_nettype wire

/* src/isaPkg.sv */
`default_nettype none

package isaPkg;

	// Funct opcodes from the decode table
	// Codes not listed decode as no-operation
	typedef enum logic [3:0]
	{
		fnSum          = 4'b0000,
		fnSub          = 4'b0001,
		fnMul          = 4'b0010,
		fnLoad         = 4'b0100,
		fnStore        = 4'b0101,
		fnGray         = 4'b1010,
		fnLoadAligned  = 4'b1011,
		fnStorePlusOne = 4'b1100
	} functCode;

	// Instruction word field positions
	localparam int functMsb   = 31;
	localparam int functLsb   = 28;
	localparam int immFlagBit = 27;
	localparam int rdMsb      = 26;
	localparam int rdLsb      = 22;
	localparam int rnMsb      = 21;
	localparam int rnLsb      = 17;
	localparam int rmMsb      = 16;
	localparam int rmLsb      = 12;
	localparam int immMsb     = 11;
	localparam int immLsb     = 0;

endpackage

`default_nettype wire

/* src/pixelAlu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "imageCore_config.svh"

module pixelAlu
(
	input  wire ctrlPkg::aluOp           op,
	input  wire [`DATA_WIDTH-1:0]        a,
	input  wire [`DATA_WIDTH-1:0]        b,
	output logic [`DATA_WIDTH-1:0]       result
);
	import ctrlPkg::*;

	// Weighted sum fits in 16 bits, max 256 * 255
	logic [15:0] grayAcc;

	// Gray weights 77, 150 and 29 over R, G and B
	always_comb
	begin
		grayAcc = 16'd77 * 16'(a[23:16])
			+ 16'd150 * 16'(a[15:8])
			+ 16'd29 * 16'(a[7:0]);
	end

	always_comb
	begin
		case (op)
			aluAdd, aluSum:
				result = a + b;
			aluSub:
				result = a - b;
			// Low half of the product only
			aluMul:
				result = a * b;
			// Divide by 256, zero-extended
			aluGray:
				result = `DATA_WIDTH'(grayAcc[15:8]);
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/pixelMemory.sv */
`timescale 1ns/1ns
`default_nettype none
`include "imageCore_config.svh"

module pixelMemory
(
	input  wire                            CLK,
	input  wire [$clog2(`MEM_BYTES)-1:0]   addr,
	input  wire                            writeEn,
	input  wire [7:0]                      writeByte,
	output logic [7:0]                     readByte,
	output logic [`DATA_WIDTH-1:0]         readWord
);
	localparam int rowCount = `MEM_BYTES / 4;
	localparam int rowBits  = $clog2(rowCount);

	// Four byte lanes, one row per aligned word
	logic [7:0] laneMem [4][rowCount];

	logic [rowBits-1:0] row;
	logic [1:0]         lane;

	// Low two bits pick the lane
	always_comb
	begin
		row  = addr[$clog2(`MEM_BYTES)-1:2];
		lane = addr[1:0];
	end

	// Byte store into one lane
	always_ff @(posedge CLK)
	begin
		if (writeEn)
		begin
			laneMem[lane][row] <= writeByte;
		end
	end

	// Synchronous read of the byte and the whole row
	always_ff @(posedge CLK)
	begin
		readByte <= laneMem[lane][row];
		// Little endian, lane 0 is the low byte
		readWord <= {laneMem[3][row], laneMem[2][row],
			laneMem[1][row], laneMem[0][row]};
	end

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none
`include "imageCore_config.svh"

module registerFile
(
	input  wire                            CLK,
	input  wire                            rstN,
	input  wire [$clog2(`REG_COUNT)-1:0]   readAddrA,
	input  wire [$clog2(`REG_COUNT)-1:0]   readAddrB,
	output logic [`DATA_WIDTH-1:0]         readDataA,
	output logic [`DATA_WIDTH-1:0]         readDataB,
	input  wire                            writeEn,
	input  wire [$clog2(`REG_COUNT)-1:0]   writeAddr,
	input  wire [`DATA_WIDTH-1:0]          writeData
);
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// All registers read zero after reset
	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Write-through so a reader in the writeback cycle sees the new value
	always_comb
	begin
		readDataA = (writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
		readDataB = (writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];
	end

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module clockGen
(
	output logic CLK,
	output logic rstN
);
	localparam int halfPeriod  = 10;
	localparam int resetCycles = 5;

	// 20 ns period
	initial
	begin
		CLK = 1'b0;
		forever #halfPeriod CLK = ~CLK;
	end

	// Reset low for the first cycles, released on a rising edge
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/imageCore_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "imageCore_config.svh"

module imageCore_tb;
	import isaPkg::*;

	localparam int regAddrW  = $clog2(`REG_COUNT);
	localparam int arithCount = 40;
	localparam int grayCount  = 12;
	localparam int storeCount = 8;
	// Fixed phases plus the looped ones, in cycles
	localparam int issueCycles = 130 + 2 * arithCount + 8 * grayCount + 8 * storeCount;
	localparam int timeoutLimit = 2 * issueCycles + 20;

	logic                   CLK;
	logic                   rstN;
	logic [31:0]            instr;
	logic                   instrValid;
	logic                   wbValid;
	logic [regAddrW-1:0]    wbAddr;
	logic [`DATA_WIDTH-1:0] wbData;

	// Register and memory model
	logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
	logic [7:0]             modelMem [`MEM_BYTES];

	// Outstanding writebacks, in issue order
	int                     dueQ [$];
	logic [regAddrW-1:0]    addrQ [$];
	logic [`DATA_WIDTH-1:0] dataQ [$];

	integer seed = 32'hc2d0_53ff;
	int     cycleCount = 0;

	clockGen i_clockGen (.CLK(CLK), .rstN(rstN));

	imageCore i_imageCore (
		.CLK(CLK), .rstN(rstN), .instr(instr), .instrValid(instrValid),
		.wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
	);

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic checkWrite(input logic [regAddrW-1:0] expAddr,
		input logic [`DATA_WIDTH-1:0] expData);
		if (wbAddr !== expAddr)
			reportFailure($sformatf("CHECK FAILED wbAddr expected %h got %h", expAddr, wbAddr));
		else if (wbData !== expData)
			reportFailure($sformatf("CHECK FAILED wbData expected %h got %h", expData, wbData));
	endtask

	task automatic compareFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			reportFailure($sformatf("CHECK FAILED %s expected %h got %h", name, expected, actual));
	endtask

	function automatic logic [31:0] randBits();
		return $random(seed);
	endfunction

	// Never r0, which stays zero as an address base
	function automatic logic [regAddrW-1:0] pickTargetReg();
		return regAddrW'(randBits() % 31) + 1'b1;
	endfunction

	function automatic logic [31:0] encode(input logic [3:0] f, input logic flag,
		input logic [4:0] rd, input logic [4:0] rn, input logic [4:0] rm,
		input logic [11:0] imm);
		return {f, flag, rd, rn, rm, imm};
	endfunction

	function automatic logic writesRegister(input logic [3:0] f);
		case (f)
			fnSum, fnSub, fnMul, fnGray, fnLoad, fnLoadAligned: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Expected writeback from the model state at issue
	function automatic logic [`DATA_WIDTH-1:0] expectedWriteback(input logic [31:0] ins);
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] b;
		logic [9:0]             addr;
		logic [9:0]             base;
		a = modelRegs[ins[rnMsb:rnLsb]];
		b = ins[immFlagBit] ? `DATA_WIDTH'(ins[immMsb:immLsb]) : modelRegs[ins[rmMsb:rmLsb]];
		addr = 10'(a + b);
		base = {addr[9:2], 2'b00};
		case (ins[functMsb:functLsb])
			fnSum: return a + b;
			fnSub: return a - b;
			fnMul: return a * b;
			// Weights 77, 150, 29 then divide by 256
			fnGray: return (32'd77 * a[23:16] + 32'd150 * a[15:8] + 32'd29 * a[7:0]) >> 8;
			fnLoad: return `DATA_WIDTH'(modelMem[addr]);
			fnLoadAligned: return {modelMem[base + 10'd3], modelMem[base + 10'd2],
				modelMem[base + 10'd1], modelMem[base]};
			default: return '0;
		endcase
	endfunction

	// Store data is immediate or Rd low byte, plus one on the plus-one store
	function automatic logic [7:0] storeData(input logic [31:0] ins);
		logic [7:0] data;
		data = ins[immFlagBit] ? ins[7:0] : modelRegs[ins[rdMsb:rdLsb]][7:0];
		if (ins[functMsb:functLsb] == fnStorePlusOne)
			data = data + 8'd1;
		return data;
	endfunction

	function automatic logic [9:0] storeAddress(input logic [31:0] ins);
		return 10'(modelRegs[ins[rnMsb:rnLsb]] + modelRegs[ins[rmMsb:rmLsb]]);
	endfunction

	task automatic issueInstr(input logic [31:0] ins);
		logic [3:0]             f;
		logic [`DATA_WIDTH-1:0] expData;
		@(posedge CLK);
		instr <= ins;
		instrValid <= 1'b1;
		f = ins[functMsb:functLsb];
		if (writesRegister(f))
		begin
			expData = expectedWriteback(ins);
			// Counter lags one edge here, so cycle t+2 reads as +3
			dueQ.push_back(cycleCount + 3);
			addrQ.push_back(ins[rdMsb:rdLsb]);
			dataQ.push_back(expData);
			modelRegs[ins[rdMsb:rdLsb]] = expData;
		end
		else if (f == fnStore || f == fnStorePlusOne)
			modelMem[storeAddress(ins)] = storeData(ins);
	endtask

	// Random junk on instr while valid is low
	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge CLK);
			instrValid <= 1'b0;
			instr <= randBits();
		end
	endtask

	task automatic arithOps();
		logic [31:0] rnd;
		logic [3:0]  f;
		for (int i = 0; i < arithCount; i++)
		begin
			rnd = randBits();
			case (rnd % 3)
				0: f = fnSum;
				1: f = fnSub;
				default: f = fnMul;
			endcase
			issueInstr(encode(f, rnd[2], pickTargetReg(), rnd[7:3], rnd[12:8], rnd[24:13]));
			idle(1);
		end
	endtask

	// Independent ops back to back, sources r1..r15, targets r16..r23
	task automatic backToBackBurst();
		logic [3:0] f;
		for (int i = 0; i < 8; i++)
		begin
			f = (i % 3 == 0) ? fnSum : ((i % 3 == 1) ? fnSub : fnMul);
			issueInstr(encode(f, 1'b0, 5'(16 + i), 5'(1 + i), 5'(8 + i), 12'd0));
		end
		idle(2);
	endtask

	task automatic grayConversions();
		logic [31:0] rnd;
		// r3 = 64 * 64 shifts a 12-bit field up
		issueInstr(encode(fnSum, 1'b1, 5'd2, 5'd0, 5'd0, 12'd64));
		idle(1);
		issueInstr(encode(fnMul, 1'b0, 5'd3, 5'd2, 5'd2, 12'd0));
		idle(1);
		for (int i = 0; i < grayCount; i++)
		begin
			rnd = randBits();
			issueInstr(encode(fnSum, 1'b1, 5'd4, 5'd0, 5'd0, rnd[23:12]));
			idle(1);
			issueInstr(encode(fnMul, 1'b0, 5'd5, 5'd4, 5'd3, 12'd0));
			idle(1);
			issueInstr(encode(fnSum, 1'b1, 5'd6, 5'd5, 5'd0, rnd[11:0]));
			idle(1);
			issueInstr(encode(fnGray, 1'b0, 5'd7, 5'd6, 5'd0, 12'd0));
			idle(1);
		end
	endtask

	// Address in r10, data in r11, loaded back into r12
	task automatic storeThenLoad();
		logic [31:0] rnd;
		logic [11:0] data;
		logic [3:0]  f;
		logic        immData;
		for (int i = 0; i < storeCount; i++)
		begin
			rnd = randBits();
			// First pass wraps 0xff plus one
			data = (i == 0) ? 12'h0ff : rnd[21:10];
			// Cycle through both store kinds and both data forms
			f = (i % 2 == 0) ? fnStorePlusOne : fnStore;
			immData = (i % 4) >= 2;
			issueInstr(encode(fnSum, 1'b1, 5'd10, 5'd0, 5'd0, 12'(rnd[9:0])));
			idle(1);
			issueInstr(encode(fnSum, 1'b1, 5'd11, 5'd0, 5'd0, data));
			idle(1);
			issueInstr(encode(f, immData, 5'd11, 5'd0, 5'd10, 12'(rnd[31:24])));
			idle(1);
			issueInstr(encode(fnLoad, 1'b1, 5'd12, 5'd10, 5'd0, 12'd0));
			idle(1);
		end
	endtask

	task automatic wordAssembly();
		logic [31:0] rnd;
		logic [9:0]  base;
		rnd = randBits();
		base = {rnd[9:2], 2'b00};
		issueInstr(encode(fnSum, 1'b1, 5'd13, 5'd0, 5'd0, 12'(base)));
		idle(1);
		for (int k = 0; k < 4; k++)
		begin
			issueInstr(encode(fnSum, 1'b1, 5'd16, 5'd0, 5'd0, 12'(base) + 12'(k)));
			idle(1);
			issueInstr(encode(fnStore, 1'b1, 5'd0, 5'd0, 5'd16, 12'(rnd[8 * k +: 8])));
			idle(1);
		end
		// Unaligned offset still returns the whole word
		issueInstr(encode(fnLoadAligned, 1'b1, 5'd17, 5'd13, 5'd0, 12'(1 + randBits() % 3)));
		idle(1);
	endtask

	task automatic unusedFunctCodes();
		logic [3:0]  unusedCodes [8] = '{4'd3, 4'd6, 4'd7, 4'd8, 4'd9, 4'd13, 4'd14, 4'd15};
		logic [31:0] rnd;
		for (int i = 0; i < 8; i++)
		begin
			rnd = randBits();
			issueInstr({unusedCodes[i], rnd[27:0]});
			idle(1);
		end
		idle(1);
		// Zero add reads every register back
		for (int r = 1; r < `REG_COUNT; r++)
			issueInstr(encode(fnSum, 1'b1, 5'(r), 5'(r), 5'd0, 12'd0));
	endtask

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit)
			reportFailure("Timeout, the run took too many cycles");
	end

	// Compare mid-cycle when outputs are settled
	always @(negedge CLK)
	begin
		if (rstN)
		begin
			if (wbValid)
			begin
				if (dueQ.size() == 0)
					reportFailure("Writeback seen with no register write outstanding");
				else if (dueQ[0] != cycleCount)
					reportFailure($sformatf("Writeback came in cycle %0d instead of cycle %0d",
						cycleCount, dueQ[0]));
				else
				begin
					void'(dueQ.pop_front());
					checkWrite(addrQ.pop_front(), dataQ.pop_front());
				end
			end
			else if (dueQ.size() != 0 && dueQ[0] <= cycleCount)
				reportFailure("Expected writeback never appeared");
		end
	end

	initial
	begin
		instr = '0;
		instrValid = 1'b0;
		for (int i = 0; i < `REG_COUNT; i++)
			modelRegs[i] = '0;
		wait (rstN === 1'b1);
		// Quiet output after reset
		repeat (5)
		begin
			@(negedge CLK);
			compareFlag("wbValid", wbValid, 1'b0);
		end
		for (int r = 1; r < `REG_COUNT; r++)
			issueInstr(encode(fnSum, 1'b1, 5'(r), 5'd0, 5'd0, 12'(randBits())));
		idle(2);
		arithOps();
		backToBackBurst();
		grayConversions();
		storeThenLoad();
		wordAssembly();
		unusedFunctCodes();
		idle(4);
		if (dueQ.size() == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			reportFailure("Run ended with writebacks still pending");
	end

endmodule

`default_nettype wire
